// File: uart_dl_top.f
common/uart_pkg.sv
common/dl_pkg.sv
uart/uart_rx.sv
uart/uart_tx.sv
design/crc16_modbus.sv
design/dl_packet_ctrl.sv
design/prog_ram.sv
design/uart_dl_top.sv
verif/uart_dl_properties.sv
verif/tb_uart_dl.sv

// File: Makefile
VERILATOR  ?= verilator
TOP        := tb_uart_dl
FILELIST   := uart_dl_top.f
BUILD_DIR  := obj_dir
LINT_FLAGS := --lint-only --timing --assert
SIM_FLAGS  := --binary --timing --assert -j 0

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

# The run fails with a non-zero exit status on any $fatal
sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)

// File: verif/tb_uart_dl.sv
/* Loader testbench: xorshift stimulus, UART host model, RAM model,
   reply deserializer and compare tasks */
`timescale 1ns/1ps

module tb_uart_dl import uart_pkg::*, dl_pkg::*; ();

    localparam int unsigned BYTE_CLKS     = FRAME_BITS * CLKS_PER_BIT;
    localparam int unsigned REPLY_TIMEOUT = 4 * BYTE_CLKS;
    localparam int unsigned QUIET_CLKS    = 2 * PKT_BYTES * BYTE_CLKS;  // Two packet times

    logic              clk;
    logic              rst_n;
    logic              dl_en;
    logic              uart_rx;
    logic              uart_tx;
    logic [RAM_AW-1:0] rd_addr;
    logic [31:0]       rd_data;
    logic              dl_done;
    logic              dl_error;

    logic [31:0] rng_state;
    logic [7:0]  pkt_buf [PKT_BYTES];
    logic [31:0] pkt_words [WORDS_PER_PKT];
    logic [31:0] ram_model [RAM_WORDS];
    logic [7:0]  reply_q [$];
    int unsigned err_cnt;
    int unsigned wr_cnt;
    int unsigned mon_tick;
    logic        mon_busy;
    logic [7:0]  mon_shift;

    uart_dl_top uart_dl_top_inst (
        .clk_i     (clk),
        .rst_n_i   (rst_n),
        .dl_en_i   (dl_en),
        .uart_rx_i (uart_rx),
        .uart_tx_o (uart_tx),
        .rd_addr_i (rd_addr),
        .rd_data_o (rd_data),
        .dl_done_o (dl_done),
        .dl_error_o(dl_error)
    );

    bind dl_packet_ctrl uart_dl_properties uart_dl_properties_inst (
        .clk_i     (clk_i),
        .rst_n_i   (rst_n_i),
        .dl_en_i   (dl_en_i),
        .wr_en_i   (wr_en_o),
        .tx_data_i (tx_data_o),
        .tx_valid_i(tx_valid_o),
        .tx_ready_i(tx_ready_i),
        .dl_done_i (dl_done_o)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic report_failure(input string what);
        $display("%s", what);
        $display("STATUS: FAIL");
        $fatal(1, "testbench stopped at the first error");
    endtask

    // Host side: replies, NAK pulses and RAM writes, sampled mid-cycle
    always @(negedge clk) begin
        if (dl_error === 1'b1) err_cnt = err_cnt + 1;
        if (uart_dl_top_inst.wr_en === 1'b1) wr_cnt = wr_cnt + 1;
        if (!mon_busy) begin
            mon_tick = 0;
            if (rst_n && uart_tx === 1'b0) mon_busy = 1'b1;   // Start bit seen
        end else begin
            mon_tick = mon_tick + 1;
            if (mon_tick % CLKS_PER_BIT == HALF_BIT) begin
                if (mon_tick / CLKS_PER_BIT == FRAME_BITS - 1) begin
                    mon_busy = 1'b0;
                    if (uart_tx !== 1'b1) report_failure("reply frame ended with a low stop bit");
                    reply_q.push_back(mon_shift);
                end else if (mon_tick > CLKS_PER_BIT) begin
                    mon_shift = {uart_tx, mon_shift[7:1]};        // LSB first
                end
            end
        end
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] next_rand();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    // Bitwise CRC-16/MODBUS over sequence byte and payload
    function automatic logic [15:0] modbus_crc();
        logic [15:0] c;
        c = CRC_INIT;
        for (int i = 0; i <= PAYLOAD_BYTES; i++) begin
            for (int b = 0; b < 8; b++) begin
                if (c[0] ^ pkt_buf[i][b]) c = (c >> 1) ^ CRC_POLY;
                else c = c >> 1;
            end
        end
        return c;
    endfunction

    task automatic seal_packet();
        logic [15:0] c;
        c = modbus_crc();
        pkt_buf[PKT_BYTES-2] = c[7:0];                       // Low byte first
        pkt_buf[PKT_BYTES-1] = c[15:8];
    endtask

    task automatic build_header(input logic [31:0] len);
        pkt_buf[0] = 8'h00;
        for (int i = 1; i <= 27; i++) begin
            pkt_buf[i] = 8'(next_rand());                     // File name
        end
        for (int i = 0; i < 4; i++) begin
            pkt_buf[28 + i] = len[8*i +: 8];
        end
        pkt_buf[32] = 8'h00;
        seal_packet();
    endtask

    task automatic build_data(input logic [7:0] seq);
        pkt_buf[0] = seq;
        for (int w = 0; w < WORDS_PER_PKT; w++) begin
            pkt_words[w] = next_rand();
            for (int b = 0; b < 4; b++) begin
                pkt_buf[1 + 4*w + b] = pkt_words[w][8*b +: 8];
            end
        end
        seal_packet();
    endtask

    task automatic send_byte(input logic [7:0] b);
        logic [9:0] frame;
        frame = {1'b1, b, 1'b0};                              // Stop, data, start
        for (int i = 0; i < FRAME_BITS; i++) begin
            uart_rx = frame[i];
            repeat (CLKS_PER_BIT) @(negedge clk);
        end
    endtask

    task automatic send_packet();
        for (int i = 0; i < PKT_BYTES; i++) begin
            send_byte(pkt_buf[i]);
        end
    endtask

    task automatic check_reply(input string name, input logic [7:0] exp, input logic [7:0] act);
        if (act !== exp)
            report_failure($sformatf("MISMATCH %s: expected %02h, actual %02h", name, exp, act));
    endtask

    task automatic check_word(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (act !== exp)
            report_failure($sformatf("MISMATCH %s: expected %08h, actual %08h", name, exp, act));
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp)
            report_failure($sformatf("MISMATCH %s: expected %0b, actual %0b", name, exp, act));
    endtask

    task automatic await_reply(input string name, input logic [7:0] exp);
        int unsigned waited;
        waited = 0;
        while (reply_q.size() == 0) begin
            if (waited == REPLY_TIMEOUT)
                report_failure($sformatf("no reply byte arrived in time for %s", name));
            @(negedge clk);
            waited++;
        end
        check_reply(name, exp, reply_q.pop_front());
    endtask

    // One packet out, one reply back, then write count and NAK pulse
    task automatic exchange(input string name, input logic [7:0] exp_reply,
                            input int unsigned exp_writes);
        int unsigned wr_before;
        int unsigned err_before;
        wr_before  = wr_cnt;
        err_before = err_cnt;
        send_packet();
        await_reply(name, exp_reply);
        check_word({name, " writes"}, 32'(exp_writes), 32'(wr_cnt - wr_before));
        check_flag({name, " error pulse"}, exp_reply == NAK_BYTE, err_cnt != err_before);
    endtask

    task automatic verify_ram(input string name, input int unsigned words);
        for (int unsigned a = 0; a < words; a++) begin
            rd_addr = RAM_AW'(a);
            @(negedge clk);                                   // Registered read
            check_word($sformatf("%s addr %0d", name, a), ram_model[a], rd_data);
        end
    endtask

    initial begin
        logic [31:0] prog_len;
        int unsigned n_pkts;
        int unsigned bad_pkt;
        int unsigned idx;
        int unsigned wr_mark;
        int unsigned err_mark;
        rng_state = 32'hcc81_e746;
        mon_busy  = 1'b0;
        mon_tick  = 0;
        mon_shift = 8'h00;
        rst_n     = 1'b0;
        dl_en     = 1'b0;
        uart_rx   = 1'b1;
        rd_addr   = '0;
        repeat (8) @(negedge clk);
        rst_n = 1'b1;
        check_flag("reset done", 1'b0, dl_done);
        check_flag("reset error", 1'b0, dl_error);
        check_flag("reset tx line", 1'b1, uart_tx);
        dl_en = 1'b1;
        @(negedge clk);

        // Length ends somewhere inside the last data packet
        n_pkts   = 1 + next_rand() % 12;
        prog_len = n_pkts * PAYLOAD_BYTES - next_rand() % PAYLOAD_BYTES;
        build_header(prog_len);
        exchange("header", ACK_BYTE, 0);
        check_flag("done after header", 1'b0, dl_done);

        bad_pkt = 1 + next_rand() % n_pkts;
        for (int unsigned k = 1; k <= n_pkts; k++) begin
            if (k == bad_pkt) begin
                build_data(8'(k));
                idx = 1 + next_rand() % PAYLOAD_BYTES;
                pkt_buf[idx] = pkt_buf[idx] ^ 8'(1 + next_rand() % 255);
                exchange("corrupt payload", NAK_BYTE, 0);
                build_data(8'(k + 1));
                exchange("skipped sequence", NAK_BYTE, 0);
            end
            build_data(8'(k));
            exchange($sformatf("data packet %0d", k), ACK_BYTE, WORDS_PER_PKT);
            for (int w = 0; w < WORDS_PER_PKT; w++) begin
                ram_model[8*(k-1) + w] = pkt_words[w];
            end
            if (k == bad_pkt) exchange("resend last good", ACK_BYTE, 0);
            check_flag($sformatf("done after packet %0d", k), k == n_pkts, dl_done);
        end
        verify_ram("fetch", n_pkts * WORDS_PER_PKT);

        dl_en = 1'b0;
        @(negedge clk);
        check_flag("done after disable", 1'b0, dl_done);
        wr_mark  = wr_cnt;
        err_mark = err_cnt;
        build_data(8'(n_pkts + 1));
        send_packet();
        repeat (QUIET_CLKS) @(negedge clk);
        check_flag("reply while disabled", 1'b0, reply_q.size() != 0);
        check_word("writes while disabled", 32'd0, 32'(wr_cnt - wr_mark));
        check_flag("error while disabled", 1'b0, err_cnt != err_mark);

        dl_en = 1'b1;
        @(negedge clk);
        prog_len = 1 + next_rand() % (12 * PAYLOAD_BYTES);
        build_header(prog_len);
        exchange("header after re-enable", ACK_BYTE, 0);
        check_flag("done after new header", 1'b0, dl_done);
        verify_ram("fetch after re-enable", n_pkts * WORDS_PER_PKT);

        $display("STATUS: PASS");
        $finish;
    end

endmodule

// File: verif/uart_dl_properties.sv
/* Bound checks on the loader controller: reply handshake,
   RAM write gating and the done flag */
`timescale 1ns/1ps

module uart_dl_properties (
    input logic       clk_i,
    input logic       rst_n_i,
    input logic       dl_en_i,
    input logic       wr_en_i,
    input logic [7:0] tx_data_i,
    input logic       tx_valid_i,
    input logic       tx_ready_i,
    input logic       dl_done_i
);

    // Reply held until the transmitter takes it
    reply_hold_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (tx_valid_i && !tx_ready_i) |=> (tx_valid_i && $stable(tx_data_i)))
        else $error("reply dropped or changed before the transmitter accepted it");

    // A disable also aborts any burst in progress
    no_write_disabled_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        !dl_en_i |-> !wr_en_i ##1 !wr_en_i)
        else $error("RAM write while or right after download is disabled");

    // Sticky while enable stays high
    done_sticky_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (dl_done_i && dl_en_i) |=> (dl_done_i || !dl_en_i))
        else $error("download done fell while download stayed enabled");

endmodule

// File: design/uart_dl_top.sv
/* Serial program loader top: UART RX/TX, loader controller, program RAM */
`timescale 1ns/1ps

module uart_dl_top import dl_pkg::*; (
    input  logic              clk_i,
    input  logic              rst_n_i,
    input  logic              dl_en_i,
    input  logic              uart_rx_i,
    output logic              uart_tx_o,
    input  logic [RAM_AW-1:0] rd_addr_i,
    output logic [31:0]       rd_data_o,
    output logic              dl_done_o,
    output logic              dl_error_o
);

    logic [7:0]        rx_data;
    logic              rx_valid;
    logic [7:0]        tx_data;
    logic              tx_valid;
    logic              tx_ready;
    logic              wr_en;
    logic [RAM_AW-1:0] wr_addr;
    logic [31:0]       wr_data;

    uart_rx uart_rx_inst (
        .clk_i  (clk_i),
        .rst_n_i(rst_n_i),
        .rx_i   (uart_rx_i),
        .data_o (rx_data),
        .valid_o(rx_valid)
    );

    dl_packet_ctrl dl_packet_ctrl_inst (
        .clk_i     (clk_i),
        .rst_n_i   (rst_n_i),
        .dl_en_i   (dl_en_i),
        .rx_data_i (rx_data),
        .rx_valid_i(rx_valid),
        .wr_en_o   (wr_en),
        .wr_addr_o (wr_addr),
        .wr_data_o (wr_data),
        .tx_data_o (tx_data),
        .tx_valid_o(tx_valid),
        .tx_ready_i(tx_ready),
        .dl_done_o (dl_done_o),
        .dl_error_o(dl_error_o)
    );

    uart_tx uart_tx_inst (
        .clk_i  (clk_i),
        .rst_n_i(rst_n_i),
        .data_i (tx_data),
        .valid_i(tx_valid),
        .ready_o(tx_ready),
        .tx_o   (uart_tx_o)
    );

    prog_ram prog_ram_inst (
        .clk_i    (clk_i),
        .wr_en_i  (wr_en),
        .wr_addr_i(wr_addr),
        .wr_data_i(wr_data),
        .rd_addr_i(rd_addr_i),
        .rd_data_o(rd_data_o)
    );

endmodule

// File: design/prog_ram.sv
/* Program word RAM, one write port and one registered read port */
`timescale 1ns/1ps

module prog_ram import dl_pkg::*; (
    input  logic              clk_i,
    input  logic              wr_en_i,
    input  logic [RAM_AW-1:0] wr_addr_i,
    input  logic [31:0]       wr_data_i,
    input  logic [RAM_AW-1:0] rd_addr_i,
    output logic [31:0]       rd_data_o
);

    logic [31:0] mem_q [RAM_WORDS];

    always_ff @(posedge clk_i) begin
        if (wr_en_i) mem_q[wr_addr_i] <= wr_data_i;
    end

    // Fetch side, data one cycle after address
    always_ff @(posedge clk_i) begin
        rd_data_o <= mem_q[rd_addr_i];
    end

endmodule

// File: design/dl_packet_ctrl.sv
/* Loader controller: packet assembly, CRC and sequence check,
   RAM write burst, ACK/NAK reply and download-done tracking */
`timescale 1ns/1ps

module dl_packet_ctrl import dl_pkg::*; (
    input  logic              clk_i,
    input  logic              rst_n_i,
    input  logic              dl_en_i,
    input  logic [7:0]        rx_data_i,
    input  logic              rx_valid_i,
    output logic              wr_en_o,
    output logic [RAM_AW-1:0] wr_addr_o,
    output logic [31:0]       wr_data_o,
    output logic [7:0]        tx_data_o,
    output logic              tx_valid_o,
    input  logic              tx_ready_i,
    output logic              dl_done_o,
    output logic              dl_error_o
);

    logic [BYTE_CNT_W-1:0] byte_cnt_q;
    logic [7:0]            seq_q;
    payload_u              payload_q;
    logic [15:0]           crc_rx_q;
    logic                  check_q;
    logic [7:0]            exp_seq_q;
    logic                  burst_q;
    logic [WIDX_W-1:0]     widx_q;
    logic [31:0]           prog_len_q;
    logic [31:0]           bytes_q;
    logic                  hdr_seen_q;
    logic                  rx_take;
    logic                  crc_clr;
    logic                  crc_en;
    logic [15:0]           crc_value;
    logic                  crc_ok;
    logic                  seq_ok;
    logic                  seq_rep;
    logic [7:0]            seq_base;

    assign rx_take = dl_en_i & rx_valid_i;
    assign crc_en  = rx_take & (byte_cnt_q <= BYTE_CNT_W'(PAYLOAD_BYTES));  // Bytes 0..32
    assign crc_clr = check_q | ~dl_en_i;

    crc16_modbus crc16_modbus_inst (
        .clk_i  (clk_i),
        .rst_n_i(rst_n_i),
        .clr_i  (crc_clr),
        .en_i   (crc_en),
        .byte_i (rx_data_i),
        .crc_o  (crc_value)
    );

    assign crc_ok  = (crc_value == crc_rx_q);
    assign seq_ok  = (seq_q == exp_seq_q);
    assign seq_rep = (exp_seq_q != 8'd0) && (seq_q == exp_seq_q - 8'd1);  // Host resend

    // Data packet k fills words 8*(k-1) .. 8*(k-1)+7
    assign seq_base  = seq_q - 8'd1;
    assign wr_addr_o = {seq_base[RAM_AW-WIDX_W-1:0], widx_q};
    assign wr_data_o = payload_q.words[widx_q];
    assign wr_en_o   = burst_q & dl_en_i;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            byte_cnt_q <= '0;
            check_q    <= 1'b0;
        end else begin
            check_q <= 1'b0;
            if (!dl_en_i) begin
                byte_cnt_q <= '0;
            end else if (rx_valid_i) begin
                if (byte_cnt_q == BYTE_CNT_W'(PKT_BYTES - 1)) begin
                    byte_cnt_q <= '0;
                    check_q    <= 1'b1;               // Compare on next cycle
                end else begin
                    byte_cnt_q <= byte_cnt_q + 1'b1;
                end
            end
        end
    end

    // Payload shifts in from the top so byte 0 ends at the LSB
    always_ff @(posedge clk_i) begin
        if (rx_take) begin
            if (byte_cnt_q == '0)
                seq_q <= rx_data_i;
            else if (byte_cnt_q <= BYTE_CNT_W'(PAYLOAD_BYTES))
                payload_q <= {rx_data_i, payload_q[PAYLOAD_BYTES*8-1:8]};
            else
                crc_rx_q <= {rx_data_i, crc_rx_q[15:8]};  // Low byte first
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            exp_seq_q  <= 8'd0;
            burst_q    <= 1'b0;
            widx_q     <= '0;
            prog_len_q <= '0;
            bytes_q    <= '0;
            hdr_seen_q <= 1'b0;
            tx_valid_o <= 1'b0;
            tx_data_o  <= ACK_BYTE;
            dl_error_o <= 1'b0;
            dl_done_o  <= 1'b0;
        end else begin
            dl_error_o <= 1'b0;
            if (tx_valid_o && tx_ready_i) tx_valid_o <= 1'b0;  // Reply handed over
            if (!dl_en_i) begin
                exp_seq_q  <= 8'd0;
                burst_q    <= 1'b0;
                hdr_seen_q <= 1'b0;
                dl_done_o  <= 1'b0;
            end else begin
                dl_done_o <= dl_done_o | (hdr_seen_q & (bytes_q >= prog_len_q));
                if (check_q) begin
                    if (!crc_ok || !(seq_ok || seq_rep)) begin
                        tx_valid_o <= 1'b1;
                        tx_data_o  <= NAK_BYTE;
                        dl_error_o <= 1'b1;
                    end else if (seq_rep) begin
                        tx_valid_o <= 1'b1;           // Ack again, no rewrite
                        tx_data_o  <= ACK_BYTE;
                    end else if (seq_q == 8'd0) begin
                        prog_len_q <= payload_q.hdr.prog_len;
                        bytes_q    <= '0;
                        hdr_seen_q <= 1'b1;
                        exp_seq_q  <= 8'd1;
                        tx_valid_o <= 1'b1;
                        tx_data_o  <= ACK_BYTE;
                    end else begin
                        burst_q   <= 1'b1;            // Ack after last word
                        widx_q    <= '0;
                        exp_seq_q <= exp_seq_q + 8'd1;
                    end
                end
                if (burst_q) begin
                    widx_q  <= widx_q + 1'b1;
                    bytes_q <= bytes_q + 32'd4;
                    if (widx_q == WIDX_W'(WORDS_PER_PKT - 1)) begin
                        burst_q    <= 1'b0;
                        tx_valid_o <= 1'b1;
                        tx_data_o  <= ACK_BYTE;
                    end
                end
            end
        end
    end

endmodule

// File: design/crc16_modbus.sv
/* Byte-wide CRC-16/MODBUS accumulator with synchronous clear */
`timescale 1ns/1ps

module crc16_modbus import dl_pkg::*; (
    input  logic        clk_i,
    input  logic        rst_n_i,
    input  logic        clr_i,
    input  logic        en_i,
    input  logic [7:0]  byte_i,
    output logic [15:0] crc_o
);

    logic [15:0] crc_q;
    logic [15:0] crc_next;

    // Eight shift steps unrolled into one cycle
    always_comb begin
        crc_next = crc_q ^ {8'h00, byte_i};
        for (int i = 0; i < 8; i++) begin
            crc_next = crc_next[0] ? ((crc_next >> 1) ^ CRC_POLY) : (crc_next >> 1);
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i)   crc_q <= CRC_INIT;
        else if (clr_i) crc_q <= CRC_INIT;            // Clear wins over enable
        else if (en_i)  crc_q <= crc_next;
    end

    assign crc_o = crc_q;

endmodule

// File: uart/uart_tx.sv
/* 8N1 UART transmitter, one byte per valid/ready transfer */
`timescale 1ns/1ps

module uart_tx import uart_pkg::*; (
    input  logic       clk_i,
    input  logic       rst_n_i,
    input  logic [7:0] data_i,
    input  logic       valid_i,
    output logic       ready_o,
    output logic       tx_o
);

    logic [FRAME_BITS-1:0] shift_q;
    logic [CNT_W-1:0]      clk_cnt_q;
    logic [3:0]            bit_cnt_q;
    logic                  busy_q;

    assign ready_o = ~busy_q;
    assign tx_o    = shift_q[0];                      // Ones when idle

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            shift_q   <= '1;
            clk_cnt_q <= '0;
            bit_cnt_q <= '0;
            busy_q    <= 1'b0;
        end else if (!busy_q) begin
            clk_cnt_q <= '0;
            bit_cnt_q <= '0;
            if (valid_i) begin
                shift_q <= {1'b1, data_i, 1'b0};      // Stop, data, start
                busy_q  <= 1'b1;
            end
        end else if (clk_cnt_q == CNT_W'(CLKS_PER_BIT - 1)) begin
            clk_cnt_q <= '0;
            shift_q   <= {1'b1, shift_q[FRAME_BITS-1:1]};
            bit_cnt_q <= bit_cnt_q + 1'b1;
            if (bit_cnt_q == 4'(FRAME_BITS - 1)) busy_q <= 1'b0;  // Stop bit done
        end else begin
            clk_cnt_q <= clk_cnt_q + 1'b1;
        end
    end

endmodule

// File: uart/uart_rx.sv
/* 8N1 UART receiver with two-flop input synchronizer,
   start-edge detect and mid-bit sampling */
`timescale 1ns/1ps

module uart_rx import uart_pkg::*; (
    input  logic       clk_i,
    input  logic       rst_n_i,
    input  logic       rx_i,
    output logic [7:0] data_o,
    output logic       valid_o
);

    logic             rx_s1;
    logic             rx_s2;
    logic             rx_q;
    logic [1:0]       state_q;
    logic [CNT_W-1:0] clk_cnt_q;
    logic [2:0]       bit_cnt_q;
    logic [7:0]       shift_q;
    logic             start_edge;
    logic             bit_end;

    assign start_edge = rx_q & ~rx_s2;                // High to low on synced line
    assign bit_end    = (clk_cnt_q == CNT_W'(CLKS_PER_BIT - 1));
    assign data_o     = shift_q;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            rx_s1 <= 1'b1;                            // Line idles high
            rx_s2 <= 1'b1;
            rx_q  <= 1'b1;
        end else begin
            rx_s1 <= rx_i;
            rx_s2 <= rx_s1;
            rx_q  <= rx_s2;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            state_q   <= RX_IDLE;
            clk_cnt_q <= '0;
            bit_cnt_q <= '0;
            valid_o   <= 1'b0;
        end else begin
            valid_o   <= 1'b0;
            clk_cnt_q <= clk_cnt_q + 1'b1;
            case (state_q)
                RX_IDLE: begin
                    clk_cnt_q <= '0;
                    if (start_edge) state_q <= RX_START;
                end
                RX_START: begin
                    if (clk_cnt_q == CNT_W'(HALF_BIT - 1)) begin
                        clk_cnt_q <= '0;
                        bit_cnt_q <= '0;
                        state_q   <= rx_s2 ? RX_IDLE : RX_DATA;   // Glitch, not a start
                    end
                end
                RX_DATA: begin
                    if (bit_end) begin
                        clk_cnt_q <= '0;
                        bit_cnt_q <= bit_cnt_q + 1'b1;
                        if (bit_cnt_q == 3'(DATA_BITS - 1)) state_q <= RX_STOP;
                    end
                end
                default: begin
                    if (bit_end) begin
                        state_q <= RX_IDLE;
                        valid_o <= rx_s2;                 // Framing error drops byte
                    end
                end
            endcase
        end
    end

    // LSB arrives first
    always_ff @(posedge clk_i) begin
        if (state_q == RX_DATA && bit_end) shift_q <= {rx_s2, shift_q[7:1]};
    end

endmodule

// File: common/dl_pkg.sv
/* Download packet format, reply codes, CRC constants, RAM size
   and the two views of a packet payload */
package dl_pkg;

    // Seq byte, 32 payload bytes, CRC low, CRC high
    localparam int unsigned PKT_BYTES     = 35;
    localparam int unsigned PAYLOAD_BYTES = 32;
    localparam int unsigned WORDS_PER_PKT = 8;
    localparam int unsigned BYTE_CNT_W    = $clog2(PKT_BYTES);
    localparam int unsigned WIDX_W        = $clog2(WORDS_PER_PKT);

    localparam int unsigned RAM_WORDS = 256;
    localparam int unsigned RAM_AW    = 8;

    localparam logic [7:0] ACK_BYTE = 8'h06;
    localparam logic [7:0] NAK_BYTE = 8'h15;

    // CRC-16/MODBUS, reflected form
    localparam logic [15:0] CRC_INIT = 16'hFFFF;
    localparam logic [15:0] CRC_POLY = 16'hA001;

    // Payload byte i sits at bits [8*i +: 8]
    typedef union packed {
        struct packed {
            logic [7:0]       reserved;              // Payload byte 31
            logic [31:0]      prog_len;              // Bytes 27..30, little endian
            logic [26:0][7:0] file_name;             // Bytes 0..26
        } hdr;
        logic [WORDS_PER_PKT-1:0][31:0] words;       // Little-endian data words
    } payload_u;

endpackage

// File: common/uart_pkg.sv
/* UART bit timing for 8N1 at CLKS_PER_BIT clocks per bit,
   plus the receiver state codes */
package uart_pkg;

    // 10 MHz clock, 625 kbaud
    localparam int unsigned CLKS_PER_BIT = 16;
    localparam int unsigned HALF_BIT     = 8;        // Mid-bit sample point

    // Counter width for one bit period
    localparam int unsigned CNT_W = $clog2(CLKS_PER_BIT);

    // Start, eight data bits, stop
    localparam int unsigned FRAME_BITS = 10;
    localparam int unsigned DATA_BITS  = 8;

    localparam logic [1:0] RX_IDLE  = 2'd0;          // Waiting for falling edge
    localparam logic [1:0] RX_START = 2'd1;          // Checking start bit
    localparam logic [1:0] RX_DATA  = 2'd2;          // Shifting data bits
    localparam logic [1:0] RX_STOP  = 2'd3;          // Checking stop bit

endpackage
